// ==== logic/radio_core_pkg.sv ====
// sample union, settings and readback bus types, widths, register offsets, saturation helper
`default_nettype none

package radio_core_pkg;

   // --------------------
   // widths
   // --------------------
   localparam int SAMPLE_W = 16;        // one I or Q component
   localparam int LED_W = 3;            // {rx, txrx_tx, txrx_rx}
   localparam int ANC_FRAC_BITS = 14;   // scale is Q1.14
   localparam int ANC_ENABLE_BIT = 31;

   // --------------------
   // bus types
   // --------------------
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   typedef logic [7:0]  rb_addr_t;
   typedef logic [63:0] rb_data_t;

   // one sample word, seen either as the raw bus word or as its I/Q halves
   typedef union packed {
      logic [2*SAMPLE_W-1:0] raw;
      struct packed {
         logic signed [SAMPLE_W-1:0] i;   // upper half
         logic signed [SAMPLE_W-1:0] q;   // lower half
      } iq;
   } iq_sample_t;

   // --------------------
   // register offsets
   // --------------------
   // daughterboard, relative to SR_DB_BASE
   localparam logic [1:0] DB_REG_MISC_OUT = 2'd0;
   localparam logic [1:0] DB_REG_GPIO_OUT = 2'd1;
   localparam logic [1:0] DB_REG_GPIO_DDR = 2'd2;
   localparam logic [1:0] DB_REG_LEDS     = 2'd3;

   // front end, relative to SR_FE_BASE
   localparam logic [0:0] FE_REG_RX_OFFSET = 1'd0;
   localparam logic [0:0] FE_REG_TX_OFFSET = 1'd1;

   // readback addresses
   localparam logic [1:0] RB_INPUTS    = 2'd0;
   localparam logic [1:0] RB_OUTPUTS   = 2'd1;
   localparam logic [1:0] RB_DIRECTION = 2'd2;

   // clamp a wide signed value to the signed sample range
   function automatic logic signed [SAMPLE_W-1:0] sat_sample(input logic signed [31:0] x);
      logic signed [31:0] max_v;
      logic signed [31:0] min_v;
      max_v = (32'sd1 <<< (SAMPLE_W - 1)) - 32'sd1;
      min_v = -(32'sd1 <<< (SAMPLE_W - 1));
      if (x > max_v) begin
         return max_v[SAMPLE_W-1:0];
      end else if (x < min_v) begin
         return min_v[SAMPLE_W-1:0];
      end
      return x[SAMPLE_W-1:0];
   endfunction

endpackage

`default_nettype wire

// ==== logic/db_control.sv ====
// daughterboard misc/gpio/led registers, input sampling, readback mux
`timescale 1ns/1ns
`default_nettype none

module db_control #(
   parameter int SR_DB_BASE = 160
) (
   input  wire logic                            radio_clk,
   input  wire logic                            i_rst_n,
   // settings bus
   input  wire logic                            i_set_stb,
   input  wire radio_core_pkg::set_addr_t       i_set_addr,
   input  wire radio_core_pkg::set_data_t       i_set_data,
   // readback
   input  wire logic                            i_rb_stb,
   input  wire radio_core_pkg::rb_addr_t        i_rb_addr,
   output logic                                 o_rb_stb,
   output radio_core_pkg::rb_data_t             o_rb_data,
   // daughterboard pins
   input  wire logic [31:0]                     i_misc_in,
   input  wire logic [31:0]                     i_gpio_in,
   output logic [31:0]                          o_misc_out,
   output logic [31:0]                          o_gpio_out,
   output logic [31:0]                          o_gpio_ddr,
   output logic [radio_core_pkg::LED_W-1:0]     o_radio_led
);

   // absolute settings addresses
   localparam radio_core_pkg::set_addr_t ADDR_MISC_OUT =
      radio_core_pkg::set_addr_t'(SR_DB_BASE + int'(radio_core_pkg::DB_REG_MISC_OUT));
   localparam radio_core_pkg::set_addr_t ADDR_GPIO_OUT =
      radio_core_pkg::set_addr_t'(SR_DB_BASE + int'(radio_core_pkg::DB_REG_GPIO_OUT));
   localparam radio_core_pkg::set_addr_t ADDR_GPIO_DDR =
      radio_core_pkg::set_addr_t'(SR_DB_BASE + int'(radio_core_pkg::DB_REG_GPIO_DDR));
   localparam radio_core_pkg::set_addr_t ADDR_LEDS =
      radio_core_pkg::set_addr_t'(SR_DB_BASE + int'(radio_core_pkg::DB_REG_LEDS));

   // readback addresses widened to the bus
   localparam radio_core_pkg::rb_addr_t RB_ADDR_INPUTS =
      radio_core_pkg::rb_addr_t'(radio_core_pkg::RB_INPUTS);
   localparam radio_core_pkg::rb_addr_t RB_ADDR_OUTPUTS =
      radio_core_pkg::rb_addr_t'(radio_core_pkg::RB_OUTPUTS);
   localparam radio_core_pkg::rb_addr_t RB_ADDR_DIRECTION =
      radio_core_pkg::rb_addr_t'(radio_core_pkg::RB_DIRECTION);

   logic [31:0] misc_in_r;   // sampled pins
   logic [31:0] gpio_in_r;
   radio_core_pkg::rb_data_t rb_mux;

   // --------------------
   // settings registers
   // --------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_misc_out  <= '0;
         o_gpio_out  <= '0;
         o_gpio_ddr  <= '0;
         o_radio_led <= '0;
      end else if (i_set_stb) begin
         case (i_set_addr)
            ADDR_MISC_OUT: o_misc_out <= i_set_data;
            ADDR_GPIO_OUT: o_gpio_out <= i_set_data;
            ADDR_GPIO_DDR: o_gpio_ddr <= i_set_data;
            ADDR_LEDS:     o_radio_led <= i_set_data[radio_core_pkg::LED_W-1:0];
            default: ;   // someone else's register
         endcase
      end
   end

   // one register stage on the pins before they reach readback
   always_ff @(posedge radio_clk) begin
      misc_in_r <= i_misc_in;
      gpio_in_r <= i_gpio_in;
   end

   // --------------------
   // readback
   // --------------------
   always_comb begin
      case (i_rb_addr)
         RB_ADDR_INPUTS:    rb_mux = {misc_in_r, gpio_in_r};
         RB_ADDR_OUTPUTS:   rb_mux = {o_misc_out, o_gpio_out};
         RB_ADDR_DIRECTION: rb_mux = {o_gpio_ddr, {(32 - radio_core_pkg::LED_W){1'b0}},
                                      o_radio_led};
         default:           rb_mux = '0;
      endcase
   end

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_rb_stb <= 1'b0;
      end else begin
         o_rb_stb <= i_rb_stb;
      end
   end

   always_ff @(posedge radio_clk) begin
      if (i_rb_stb) begin
         o_rb_data <= rb_mux;   // held until the next request
      end
   end

   // every request gets exactly one answer, on the next cycle
   assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_rb_stb == $past(i_rb_stb && i_rst_n));

endmodule

`default_nettype wire

// ==== logic/fe_control.sv ====
// rx/tx dc-offset registers and the saturating offset correction stages
`timescale 1ns/1ns
`default_nettype none

module fe_control #(
   parameter int SR_FE_BASE = 208
) (
   input  wire logic                            radio_clk,
   input  wire logic                            i_rst_n,
   // settings bus
   input  wire logic                            i_set_stb,
   input  wire radio_core_pkg::set_addr_t       i_set_addr,
   input  wire radio_core_pkg::set_data_t       i_set_data,
   // receive side
   input  wire logic                            i_rx_stb,
   input  wire radio_core_pkg::iq_sample_t      i_rx_data,
   output logic                                 o_rx_stb,
   output radio_core_pkg::iq_sample_t           o_rx_data,
   // transmit side
   input  wire logic                            i_tx_stb,
   input  wire radio_core_pkg::iq_sample_t      i_tx_data,
   output logic                                 o_tx_stb,
   output radio_core_pkg::iq_sample_t           o_tx_data
);

   localparam radio_core_pkg::set_addr_t ADDR_RX_OFFSET =
      radio_core_pkg::set_addr_t'(SR_FE_BASE + int'(radio_core_pkg::FE_REG_RX_OFFSET));
   localparam radio_core_pkg::set_addr_t ADDR_TX_OFFSET =
      radio_core_pkg::set_addr_t'(SR_FE_BASE + int'(radio_core_pkg::FE_REG_TX_OFFSET));

   radio_core_pkg::iq_sample_t rx_offset;
   radio_core_pkg::iq_sample_t tx_offset;

   // 32 bit so the sum never wraps before the clamp
   logic signed [31:0] rx_i_wide;
   logic signed [31:0] rx_q_wide;
   logic signed [31:0] tx_i_wide;
   logic signed [31:0] tx_q_wide;

   // --------------------
   // offset registers
   // --------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         rx_offset.raw <= '0;
         tx_offset.raw <= '0;
      end else if (i_set_stb) begin
         if (i_set_addr == ADDR_RX_OFFSET) begin
            rx_offset.raw <= i_set_data;
         end
         if (i_set_addr == ADDR_TX_OFFSET) begin
            tx_offset.raw <= i_set_data;
         end
      end
   end

   always_comb begin
      rx_i_wide = 32'(i_rx_data.iq.i) - 32'(rx_offset.iq.i);   // remove dc
      rx_q_wide = 32'(i_rx_data.iq.q) - 32'(rx_offset.iq.q);
      tx_i_wide = 32'(i_tx_data.iq.i) + 32'(tx_offset.iq.i);   // add dc back for the dac
      tx_q_wide = 32'(i_tx_data.iq.q) + 32'(tx_offset.iq.q);
   end

   // --------------------
   // strobes
   // --------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_rx_stb <= 1'b0;
         o_tx_stb <= 1'b0;
      end else begin
         o_rx_stb <= i_rx_stb;
         o_tx_stb <= i_tx_stb;
      end
   end

   // corrected samples, loaded only with a valid input
   always_ff @(posedge radio_clk) begin
      if (i_rx_stb) begin
         o_rx_data.iq.i <= radio_core_pkg::sat_sample(rx_i_wide);
         o_rx_data.iq.q <= radio_core_pkg::sat_sample(rx_q_wide);
      end
      if (i_tx_stb) begin
         o_tx_data.iq.i <= radio_core_pkg::sat_sample(tx_i_wide);
         o_tx_data.iq.q <= radio_core_pkg::sat_sample(tx_q_wide);
      end
   end

   // both stages are exactly one cycle deep
   assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_rx_stb == $past(i_rx_stb && i_rst_n));
   assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_tx_stb == $past(i_tx_stb && i_rst_n));

endmodule

`default_nettype wire

// ==== logic/rx_anc.sv ====
// cancellation register and two-stage scale, shift, negate pipeline
`timescale 1ns/1ns
`default_nettype none

module rx_anc #(
   parameter int SR_ANC_ADDR = 224
) (
   input  wire logic                            radio_clk,
   input  wire logic                            i_rst_n,
   // settings bus
   input  wire logic                            i_set_stb,
   input  wire radio_core_pkg::set_addr_t       i_set_addr,
   input  wire radio_core_pkg::set_data_t       i_set_data,
   // corrected receive samples in
   input  wire logic                            i_rx_stb,
   input  wire radio_core_pkg::iq_sample_t      i_rx_data,
   // cancellation samples out
   output logic                                 o_anc_stb,
   output radio_core_pkg::iq_sample_t           o_anc_data
);

   localparam radio_core_pkg::set_addr_t ADDR_ANC =
      radio_core_pkg::set_addr_t'(SR_ANC_ADDR);

   radio_core_pkg::set_data_t anc_reg;   // {en, ..., scale[15:0]}
   logic signed [radio_core_pkg::SAMPLE_W-1:0] anc_scale;
   logic anc_en;

   // stage 1
   logic               s1_stb;
   logic               s1_en;
   logic signed [31:0] prod_i;
   logic signed [31:0] prod_q;

   // stage 2 inputs
   logic signed [31:0] neg_i;
   logic signed [31:0] neg_q;

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         anc_reg <= '0;   // cancellation off
      end else if (i_set_stb && i_set_addr == ADDR_ANC) begin
         anc_reg <= i_set_data;
      end
   end

   assign anc_scale = anc_reg[radio_core_pkg::SAMPLE_W-1:0];
   assign anc_en    = anc_reg[radio_core_pkg::ANC_ENABLE_BIT];

   // --------------------
   // stage 1 multiply
   // --------------------
   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         s1_stb <= 1'b0;
         s1_en  <= 1'b0;
      end else begin
         s1_stb <= i_rx_stb;
         s1_en  <= anc_en;   // enable travels with the sample
      end
   end

   always_ff @(posedge radio_clk) begin
      if (i_rx_stb) begin
         prod_i <= i_rx_data.iq.i * anc_scale;
         prod_q <= i_rx_data.iq.q * anc_scale;
      end
   end

   // --------------------
   // stage 2 shift, negate, clamp
   // --------------------
   assign neg_i = -(prod_i >>> radio_core_pkg::ANC_FRAC_BITS);
   assign neg_q = -(prod_q >>> radio_core_pkg::ANC_FRAC_BITS);

   always_ff @(posedge radio_clk) begin
      if (!i_rst_n) begin
         o_anc_stb <= 1'b0;
      end else begin
         o_anc_stb <= s1_stb;
      end
   end

   always_ff @(posedge radio_clk) begin
      if (s1_stb) begin
         if (s1_en) begin
            o_anc_data.iq.i <= radio_core_pkg::sat_sample(neg_i);
            o_anc_data.iq.q <= radio_core_pkg::sat_sample(neg_q);
         end else begin
            o_anc_data.raw <= '0;   // silence while disabled
         end
      end
   end

   // a valid cancellation sample is always fully defined
   assert property (@(posedge radio_clk) disable iff (!i_rst_n)
      o_anc_stb |-> !$isunknown(o_anc_data));

endmodule

`default_nettype wire

// ==== logic/radio_core.sv ====
// top level with daughterboard control, front-end correction and cancellation
`timescale 1ns/1ns
`default_nettype none

module radio_core #(
   parameter int SR_DB_BASE  = 160,
   parameter int SR_FE_BASE  = 208,
   parameter int SR_ANC_ADDR = 224
) (
   input  wire logic                            radio_clk,
   input  wire logic                            i_rst_n,
   // settings bus
   input  wire logic                            i_set_stb,
   input  wire radio_core_pkg::set_addr_t       i_set_addr,
   input  wire radio_core_pkg::set_data_t       i_set_data,
   // readback
   input  wire logic                            i_rb_stb,
   input  wire radio_core_pkg::rb_addr_t        i_rb_addr,
   output logic                                 o_rb_stb,
   output radio_core_pkg::rb_data_t             o_rb_data,
   // samples
   input  wire logic                            i_rx_stb,
   input  wire radio_core_pkg::iq_sample_t      i_rx_data,
   output logic                                 o_rx_stb,
   output radio_core_pkg::iq_sample_t           o_rx_data,
   output logic                                 o_tx_stb,
   output radio_core_pkg::iq_sample_t           o_tx_data,
   // daughterboard
   input  wire logic [31:0]                     i_misc_in,
   output logic [31:0]                          o_misc_out,
   input  wire logic [31:0]                     i_gpio_in,
   output logic [31:0]                          o_gpio_out,
   output logic [31:0]                          o_gpio_ddr,
   output logic [radio_core_pkg::LED_W-1:0]     o_radio_led
);

   logic                       anc_stb;
   radio_core_pkg::iq_sample_t anc_data;   // negated rx fed back as tx

   // --------------------
   // daughterboard control
   // --------------------
   db_control #(
      .SR_DB_BASE (SR_DB_BASE)
   ) db_control_i (
      .radio_clk   (radio_clk),
      .i_rst_n     (i_rst_n),
      .i_set_stb   (i_set_stb),
      .i_set_addr  (i_set_addr),
      .i_set_data  (i_set_data),
      .i_rb_stb    (i_rb_stb),
      .i_rb_addr   (i_rb_addr),
      .o_rb_stb    (o_rb_stb),
      .o_rb_data   (o_rb_data),
      .i_misc_in   (i_misc_in),
      .i_gpio_in   (i_gpio_in),
      .o_misc_out  (o_misc_out),
      .o_gpio_out  (o_gpio_out),
      .o_gpio_ddr  (o_gpio_ddr),
      .o_radio_led (o_radio_led)
   );

   // rx correction first, tx correction takes the anc output
   fe_control #(
      .SR_FE_BASE (SR_FE_BASE)
   ) fe_control_i (
      .radio_clk  (radio_clk),
      .i_rst_n    (i_rst_n),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .i_rx_stb   (i_rx_stb),
      .i_rx_data  (i_rx_data),
      .o_rx_stb   (o_rx_stb),
      .o_rx_data  (o_rx_data),
      .i_tx_stb   (anc_stb),
      .i_tx_data  (anc_data),
      .o_tx_stb   (o_tx_stb),
      .o_tx_data  (o_tx_data)
   );

   rx_anc #(
      .SR_ANC_ADDR (SR_ANC_ADDR)
   ) rx_anc_i (
      .radio_clk  (radio_clk),
      .i_rst_n    (i_rst_n),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .i_rx_stb   (o_rx_stb),    // corrected rx
      .i_rx_data  (o_rx_data),
      .o_anc_stb  (anc_stb),
      .o_anc_data (anc_data)
   );

endmodule

`default_nettype wire

// ==== test/radio_core_tb.sv ====
// clock and reset, xorshift stimulus, reference model with expected queues, compare tasks, timeout
`timescale 1ns/1ns
`default_nettype none

module radio_core_tb;

   localparam int DB_BASE    = 160;
   localparam int FE_BASE    = 208;
   localparam int ANC_ADDR   = 224;
   localparam int MAX_CYCLES = 3000;   // about twice the full run

   localparam logic [7:0] A_MISC = 8'(DB_BASE + int'(radio_core_pkg::DB_REG_MISC_OUT));
   localparam logic [7:0] A_GPIO = 8'(DB_BASE + int'(radio_core_pkg::DB_REG_GPIO_OUT));
   localparam logic [7:0] A_DDR  = 8'(DB_BASE + int'(radio_core_pkg::DB_REG_GPIO_DDR));
   localparam logic [7:0] A_LEDS = 8'(DB_BASE + int'(radio_core_pkg::DB_REG_LEDS));
   localparam logic [7:0] A_RXOF = 8'(FE_BASE + int'(radio_core_pkg::FE_REG_RX_OFFSET));
   localparam logic [7:0] A_TXOF = 8'(FE_BASE + int'(radio_core_pkg::FE_REG_TX_OFFSET));
   localparam logic [7:0] A_ANC  = 8'(ANC_ADDR);

   logic radio_clk;
   logic i_rst_n;
   logic i_set_stb;
   radio_core_pkg::set_addr_t i_set_addr;
   radio_core_pkg::set_data_t i_set_data;
   logic i_rb_stb;
   radio_core_pkg::rb_addr_t i_rb_addr;
   logic o_rb_stb;
   radio_core_pkg::rb_data_t o_rb_data;
   logic i_rx_stb;
   radio_core_pkg::iq_sample_t i_rx_data;
   logic o_rx_stb;
   radio_core_pkg::iq_sample_t o_rx_data;
   logic o_tx_stb;
   radio_core_pkg::iq_sample_t o_tx_data;
   logic [31:0] i_misc_in;
   logic [31:0] o_misc_out;
   logic [31:0] i_gpio_in;
   logic [31:0] o_gpio_out;
   logic [31:0] o_gpio_ddr;
   logic [radio_core_pkg::LED_W-1:0] o_radio_led;

   // --------------------
   // model state
   // --------------------
   logic [31:0] m_misc;
   logic [31:0] m_gpio;
   logic [31:0] m_ddr;
   logic [radio_core_pkg::LED_W-1:0] m_led;
   radio_core_pkg::iq_sample_t m_rx_off;
   radio_core_pkg::iq_sample_t m_tx_off;
   logic [31:0] m_anc;
   logic [31:0] prev_misc;   // pins driven one cycle back
   logic [31:0] prev_gpio;

   radio_core_pkg::iq_sample_t rx_exp[$];
   int rx_due[$];
   radio_core_pkg::iq_sample_t tx_exp[$];
   int tx_due[$];
   radio_core_pkg::rb_data_t rb_exp[$];
   int rb_due[$];

   logic [31:0] rng_state;
   int cyc = 0;

   radio_core #(
      .SR_DB_BASE  (DB_BASE),
      .SR_FE_BASE  (FE_BASE),
      .SR_ANC_ADDR (ANC_ADDR)
   ) dut (
      .radio_clk   (radio_clk),
      .i_rst_n     (i_rst_n),
      .i_set_stb   (i_set_stb),
      .i_set_addr  (i_set_addr),
      .i_set_data  (i_set_data),
      .i_rb_stb    (i_rb_stb),
      .i_rb_addr   (i_rb_addr),
      .o_rb_stb    (o_rb_stb),
      .o_rb_data   (o_rb_data),
      .i_rx_stb    (i_rx_stb),
      .i_rx_data   (i_rx_data),
      .o_rx_stb    (o_rx_stb),
      .o_rx_data   (o_rx_data),
      .o_tx_stb    (o_tx_stb),
      .o_tx_data   (o_tx_data),
      .i_misc_in   (i_misc_in),
      .o_misc_out  (o_misc_out),
      .i_gpio_in   (i_gpio_in),
      .o_gpio_out  (o_gpio_out),
      .o_gpio_ddr  (o_gpio_ddr),
      .o_radio_led (o_radio_led)
   );

   always #2 radio_clk = ~radio_clk;   // 4 ns period

   // --------------------
   // error exit
   // --------------------
   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("sim failed");
      $fatal(1, "stopped at first error");
   endtask

   always @(posedge radio_clk) begin
      cyc <= cyc + 1;
      if (cyc == MAX_CYCLES) begin
         fail_run($sformatf("run exceeded %0d cycles without finishing", MAX_CYCLES));
      end
   end

   task automatic check_sample(input string name, input radio_core_pkg::iq_sample_t exp_v,
                               input radio_core_pkg::iq_sample_t act_v);
      if (act_v !== exp_v) begin
         fail_run($sformatf("Mismatch at %0t ns: %s expected %h, got %h",
                            $time, name, exp_v.raw, act_v.raw));
      end
   endtask

   task automatic check_rb(input string name, input radio_core_pkg::rb_data_t exp_v,
                           input radio_core_pkg::rb_data_t act_v);
      if (act_v !== exp_v) begin
         fail_run($sformatf("Mismatch at %0t ns: %s expected %h, got %h",
                            $time, name, exp_v, act_v));
      end
   endtask

   task automatic check_reg(input string name, input logic [31:0] exp_v,
                            input logic [31:0] act_v);
      if (act_v !== exp_v) begin
         fail_run($sformatf("Mismatch at %0t ns: %s expected %h, got %h",
                            $time, name, exp_v, act_v));
      end
   endtask

   // --------------------
   // random numbers
   // --------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function logic [31:0] rand32();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // half the time a value close to full scale
   function automatic logic [15:0] rand_component();
      logic [31:0] r;
      r = rand32();
      case (r[1:0])
         2'd0:    return 16'h7fff - {10'd0, r[7:2]};
         2'd1:    return 16'h8000 + {10'd0, r[7:2]};
         default: return r[31:16];
      endcase
   endfunction

   // --------------------
   // reference model
   // --------------------
   function automatic logic signed [15:0] clamp16(input longint v);
      if (v > 32767) begin
         return 16'sh7fff;
      end
      if (v < -32768) begin
         return 16'sh8000;
      end
      return v[15:0];
   endfunction

   function automatic radio_core_pkg::iq_sample_t expected_tx(
      input radio_core_pkg::iq_sample_t c);
      radio_core_pkg::iq_sample_t t;
      logic signed [15:0] scale;
      logic signed [15:0] ci;
      logic signed [15:0] cq;
      scale = m_anc[15:0];
      if (m_anc[radio_core_pkg::ANC_ENABLE_BIT]) begin
         ci = clamp16(-((longint'(c.iq.i) * longint'(scale)) >>> radio_core_pkg::ANC_FRAC_BITS));
         cq = clamp16(-((longint'(c.iq.q) * longint'(scale)) >>> radio_core_pkg::ANC_FRAC_BITS));
      end else begin
         ci = 16'sd0;
         cq = 16'sd0;
      end
      t.iq.i = clamp16(longint'(ci) + longint'(m_tx_off.iq.i));
      t.iq.q = clamp16(longint'(cq) + longint'(m_tx_off.iq.q));
      return t;
   endfunction

   function automatic radio_core_pkg::rb_data_t expected_rb(input radio_core_pkg::rb_addr_t a);
      if (a == radio_core_pkg::rb_addr_t'(radio_core_pkg::RB_INPUTS)) begin
         return {prev_misc, prev_gpio};
      end
      if (a == radio_core_pkg::rb_addr_t'(radio_core_pkg::RB_OUTPUTS)) begin
         return {m_misc, m_gpio};
      end
      if (a == radio_core_pkg::rb_addr_t'(radio_core_pkg::RB_DIRECTION)) begin
         return {m_ddr, 29'd0, m_led};
      end
      return 64'd0;   // unknown address
   endfunction

   task automatic check_cycle();
      radio_core_pkg::iq_sample_t exp_s;
      radio_core_pkg::rb_data_t exp_r;
      check_reg("o_misc_out", m_misc, o_misc_out);
      check_reg("o_gpio_out", m_gpio, o_gpio_out);
      check_reg("o_gpio_ddr", m_ddr, o_gpio_ddr);
      check_reg("o_radio_led", 32'(m_led), 32'(o_radio_led));
      if (rx_due.size() > 0 && rx_due[0] == cyc) begin
         if (!o_rx_stb) begin
            fail_run($sformatf("receive strobe expected at cycle %0d never came", cyc));
         end else begin
            exp_s = rx_exp.pop_front();
            void'(rx_due.pop_front());
            check_sample("o_rx_data", exp_s, o_rx_data);
         end
      end else if (o_rx_stb) begin
         fail_run($sformatf("receive strobe at cycle %0d without a sample", cyc));
      end
      if (tx_due.size() > 0 && tx_due[0] == cyc) begin
         if (!o_tx_stb) begin
            fail_run($sformatf("transmit strobe expected at cycle %0d never came", cyc));
         end else begin
            exp_s = tx_exp.pop_front();
            void'(tx_due.pop_front());
            check_sample("o_tx_data", exp_s, o_tx_data);
         end
      end else if (o_tx_stb) begin
         fail_run($sformatf("transmit strobe at cycle %0d without a sample", cyc));
      end
      if (rb_due.size() > 0 && rb_due[0] == cyc) begin
         if (!o_rb_stb) begin
            fail_run($sformatf("readback strobe expected at cycle %0d never came", cyc));
         end else begin
            exp_r = rb_exp.pop_front();
            void'(rb_due.pop_front());
            check_rb("o_rb_data", exp_r, o_rb_data);
         end
      end else if (o_rb_stb) begin
         fail_run($sformatf("readback strobe at cycle %0d without a request", cyc));
      end
   endtask

   // --------------------
   // drivers
   // --------------------
   task automatic next_cycle();
      @(negedge radio_clk);
      prev_misc = i_misc_in;
      prev_gpio = i_gpio_in;
      check_cycle();
      i_set_stb = 1'b0;   // strobes are single cycle
      i_rb_stb  = 1'b0;
      i_rx_stb  = 1'b0;
   endtask

   task automatic drive_write(input logic [7:0] a, input logic [31:0] d);
      i_set_stb  = 1'b1;
      i_set_addr = a;
      i_set_data = d;
      if (a == A_MISC) m_misc = d;
      if (a == A_GPIO) m_gpio = d;
      if (a == A_DDR)  m_ddr = d;
      if (a == A_LEDS) m_led = d[radio_core_pkg::LED_W-1:0];
      if (a == A_RXOF) m_rx_off.raw = d;
      if (a == A_TXOF) m_tx_off.raw = d;
      if (a == A_ANC)  m_anc = d;
   endtask

   task automatic write_setting(input logic [7:0] a, input logic [31:0] d);
      next_cycle();
      drive_write(a, d);
   endtask

   task automatic drive_readback(input radio_core_pkg::rb_addr_t a);
      i_rb_stb  = 1'b1;
      i_rb_addr = a;
      rb_exp.push_back(expected_rb(a));
      rb_due.push_back(cyc + 1);
   endtask

   task automatic drive_sample();
      radio_core_pkg::iq_sample_t s;
      radio_core_pkg::iq_sample_t c;
      s.iq.i = rand_component();
      s.iq.q = rand_component();
      c.iq.i = clamp16(longint'(s.iq.i) - longint'(m_rx_off.iq.i));
      c.iq.q = clamp16(longint'(s.iq.q) - longint'(m_rx_off.iq.q));
      i_rx_stb  = 1'b1;
      i_rx_data = s;
      rx_exp.push_back(c);
      rx_due.push_back(cyc + 1);
      tx_exp.push_back(expected_tx(c));
      tx_due.push_back(cyc + 4);   // rx, two anc stages, tx
   endtask

   task automatic drain();
      while (rx_due.size() > 0 || tx_due.size() > 0 || rb_due.size() > 0) begin
         next_cycle();
      end
   endtask

   initial begin
      int n;
      int round;
      logic [31:0] r;
      radio_clk  = 1'b0;
      i_rst_n    = 1'b0;
      // strobes held high through reset, a write would enable cancellation
      i_set_stb  = 1'b1;
      i_set_addr = A_ANC;
      i_set_data = '1;
      i_rb_stb   = 1'b1;
      i_rb_addr  = '0;
      i_rx_stb   = 1'b1;
      i_rx_data  = '0;
      i_misc_in  = '0;
      i_gpio_in  = '0;
      m_misc     = '0;
      m_gpio     = '0;
      m_ddr      = '0;
      m_led      = '0;
      m_rx_off   = '0;
      m_tx_off   = '0;
      m_anc      = '0;
      rng_state  = 32'hba24;
      repeat (10) @(posedge radio_clk);
      @(negedge radio_clk);
      i_rst_n   = 1'b1;
      i_set_stb = 1'b0;
      i_rb_stb  = 1'b0;
      i_rx_stb  = 1'b0;

      // tx stays silent after reset with cancellation off
      next_cycle();
      if (o_rx_stb !== 1'b0 || o_tx_stb !== 1'b0 || o_rb_stb !== 1'b0) begin
         fail_run("an output strobe is not low right after reset");
      end
      for (n = 0; n < 30; n++) begin
         next_cycle();
         r = rand32();
         if (r[0]) drive_sample();
      end
      drain();

      // register writes with half going to random addresses
      for (n = 0; n < 200; n++) begin
         next_cycle();
         r = rand32();
         if (r[4] || r[5]) begin
            drive_write(r[0] ? (A_MISC + {6'd0, r[3:2]}) : r[15:8], rand32());
         end
      end

      // readback with moving input pins
      for (n = 0; n < 200; n++) begin
         next_cycle();
         i_misc_in = rand32();
         i_gpio_in = rand32();
         r = rand32();
         if (r[0]) drive_readback(r[1] ? radio_core_pkg::rb_addr_t'(r[3:2]) : r[15:8]);
         if (r[4] && r[5]) drive_write(A_MISC + {6'd0, r[7:6]}, rand32());
      end
      drain();

      // receive correction
      for (round = 0; round < 4; round++) begin
         r = rand32();
         write_setting(A_RXOF, round[0] ? (r & 32'h00ff_00ff) : r);
         for (n = 0; n < 60; n++) begin
            next_cycle();
            r = rand32();
            if (r[0]) drive_sample();
         end
         drain();
      end

      // cancellation and tx correction with samples back to back
      for (round = 0; round < 6; round++) begin
         write_setting(A_RXOF, rand32());
         write_setting(A_TXOF, rand32());
         write_setting(A_ANC, rand32() | 32'h8000_0000);
         for (n = 0; n < 80; n++) begin
            next_cycle();
            r = rand32();
            if (r[1:0] != 2'd0) drive_sample();
         end
         drain();
      end

      repeat (3) next_cycle();
      $display("sim passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== radio_core.f ====
logic/radio_core_pkg.sv
logic/db_control.sv
logic/fe_control.sv
logic/rx_anc.sv
logic/radio_core.sv
test/radio_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert --timescale 1ns/1ns \
   --top-module radio_core_tb -f radio_core.f -o radio_core_sim
if [ $? -ne 0 ]; then
   echo "FAIL: Verilator build did not complete"
   exit 1
fi

./obj_dir/radio_core_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
   echo "FAIL: testbench reported an error"
   exit 1
fi
if [ $run_status -ne 0 ]; then
   echo "FAIL: simulator exited with status $run_status"
   exit 1
fi

echo "PASS"
exit 0
